/* hw/ig_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_cfg_regs (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cfg_wr,
    input  wire logic [1:0]            cfg_addr,
    input  wire ig_ctrl_pkg::cfg_data_t cfg_wdata,
    output ig_ctrl_pkg::cfg_data_t     cfg_rdata,
    input  wire logic                  last_written,
    output ig_pixel_pkg::coord_t       cfg_width,
    output ig_pixel_pkg::coord_t       cfg_height,
    output logic                       cfg_start,
    output logic                       done
);
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;

    cfg_reg_e reg_sel;

    assign reg_sel = cfg_reg_e'(cfg_addr);

    // ------------------------------
    // register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_width  <= coord_t'(`IG_MAX_DIM);
            cfg_height <= coord_t'(`IG_MAX_DIM);
            cfg_start  <= 1'b0;
        end else begin
            // start is a single cycle pulse
            cfg_start <= 1'b0;
            if (cfg_wr) begin
                case (reg_sel)
                    REG_WIDTH:  cfg_width <= coord_t'(cfg_wdata);
                    REG_HEIGHT: cfg_height <= coord_t'(cfg_wdata);
                    REG_CTRL:   cfg_start <= cfg_wdata[0];
                    default:    ;
                endcase
            end
        end
    end

    // done holds until the next frame is started
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (cfg_start) begin
            done <= 1'b0;
        end else if (last_written) begin
            done <= 1'b1;
        end
    end

    // ------------------------------
    // read decode
    always_comb begin
        case (reg_sel)
            REG_WIDTH:  cfg_rdata = cfg_data_t'(cfg_width);
            REG_HEIGHT: cfg_rdata = cfg_data_t'(cfg_height);
            REG_STATUS: cfg_rdata = cfg_data_t'(done);
            // ctrl reads back as zero
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/ig_ctrl_pkg.sv */
`default_nettype none

`include "ig_defs.svh"

package ig_ctrl_pkg;

    // register data as seen on the cfg port
    typedef logic [15:0] cfg_data_t;

    // ------------------------------
    // register indices
    typedef enum logic [1:0] {
        REG_WIDTH  = `IG_REG_WIDTH,
        REG_HEIGHT = `IG_REG_HEIGHT,
        REG_CTRL   = `IG_REG_CTRL,
        REG_STATUS = `IG_REG_STATUS
    } cfg_reg_e;

    // ------------------------------
    // fetch sequencer
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_FLUSH,
        FETCH_DRAIN
    } fetch_state_e;

endpackage

`default_nettype wire

/* hw/ig_defs.svh */
`ifndef IG_DEFS_SVH
`define IG_DEFS_SVH

// ------------------------------
// image geometry
// largest width or height in pixels
`define IG_MAX_DIM 256

// ------------------------------
// flow control
// write credits granted by the gradient memory at reset
`define IG_GRAD_CREDITS 4
// output fifo entries, also the fetch stage's internal credits
`define IG_FIFO_DEPTH 4

// ------------------------------
// register map offsets
`define IG_REG_WIDTH 2'd0
`define IG_REG_HEIGHT 2'd1
`define IG_REG_CTRL 2'd2
`define IG_REG_STATUS 2'd3

`endif

/* hw/ig_grad_calc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_grad_calc (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire ig_pixel_pkg::coord_t  cfg_width,
    input  wire ig_pixel_pkg::coord_t  cfg_height,
    input  wire logic                  pix_valid,
    input  wire ig_pixel_pkg::coord_t  pix_col,
    input  wire logic                  pix_first_row,
    input  wire logic                  flush_valid,
    input  wire ig_pixel_pkg::pixel_t  img_di,
    output logic                       out_valid,
    output ig_pixel_pkg::mem_addr_t    out_addr,
    output ig_pixel_pkg::grad_word_t   out_word
);
    import ig_pixel_pkg::*;

    // previous row by column
    pixel_t line_buf [0:`IG_MAX_DIM-1];

    coord_t     out_row;
    pixel_t     cur_pix;
    pixel_t     right_pix;
    grad_comp_t gx;
    grad_comp_t gy;
    logic       last_col;
    logic       last_row;
    logic       emit;

    // ------------------------------
    // neighbour lookup
    // entry c+1 has not been overwritten yet, so it still holds row r
    assign last_col  = (pix_col == cfg_width - 9'd1);
    assign last_row  = (out_row == cfg_height - 9'd1);
    assign cur_pix   = line_buf[pix_col[7:0]];
    assign right_pix = line_buf[pix_col[7:0] + 8'd1];

    // first row only primes the buffer
    assign emit = (pix_valid && !pix_first_row) || flush_valid;

    // ------------------------------
    // subtractors
    always_comb begin
        if (last_col) begin
            gx = '0;
        end else begin
            gx = grad_comp_t'({2'b00, right_pix}) - grad_comp_t'({2'b00, cur_pix});
        end
        // flush beats carry the last row with nothing below it
        if (flush_valid) begin
            gy = '0;
        end else begin
            gy = grad_comp_t'({2'b00, img_di}) - grad_comp_t'({2'b00, cur_pix});
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_buf[pix_col[7:0]] <= img_di;
        end
    end

    // ------------------------------
    // output row counter wraps to zero at the end of the frame
    always_ff @(posedge clk) begin
        if (reset) begin
            out_row <= '0;
        end else if (emit && last_col) begin
            if (last_row) begin
                out_row <= '0;
            end else begin
                out_row <= out_row + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        out_word <= {gx, gy};
        out_addr <= mem_addr_t'(out_row) * mem_addr_t'(cfg_width) + mem_addr_t'(pix_col);
    end

endmodule

`default_nettype wire

/* hw/ig_grad_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_grad_writer (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire ig_pixel_pkg::coord_t     cfg_width,
    input  wire ig_pixel_pkg::coord_t     cfg_height,
    input  wire logic                     out_valid,
    input  wire ig_pixel_pkg::mem_addr_t  out_addr,
    input  wire ig_pixel_pkg::grad_word_t out_word,
    input  wire logic                     grad_credit,
    output logic                          grad_wr,
    output ig_pixel_pkg::mem_addr_t       grad_addr,
    output ig_pixel_pkg::grad_word_t      grad_do,
    output logic                          slot_free,
    output logic                          last_written
);
    import ig_pixel_pkg::*;

    localparam int DEPTH  = `IG_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`IG_GRAD_CREDITS + 1);

    mem_addr_t  fifo_addr [0:DEPTH-1];
    grad_word_t fifo_word [0:DEPTH-1];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    mem_addr_t         frame_last;
    logic              pop;

    // 256 x 256 wraps to zero, so minus one still gives 16'hffff
    assign frame_last = mem_addr_t'(cfg_width) * mem_addr_t'(cfg_height) - 16'd1;
    assign pop        = (count != '0) && (credits != '0);

    // ------------------------------
    // fifo
    always_ff @(posedge clk) begin
        if (out_valid) begin
            fifo_addr[wr_ptr] <= out_addr;
            fifo_word[wr_ptr] <= out_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (out_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(out_valid) - CNT_W'(pop);
        end
    end

    // ------------------------------
    // external credits and write port
    always_ff @(posedge clk) begin
        if (reset) begin
            credits      <= CRED_W'(`IG_GRAD_CREDITS);
            grad_wr      <= 1'b0;
            slot_free    <= 1'b0;
            last_written <= 1'b0;
        end else begin
            credits      <= credits - CRED_W'(pop) + CRED_W'(grad_credit);
            grad_wr      <= pop;
            slot_free    <= pop;
            last_written <= pop && (fifo_addr[rd_ptr] == frame_last);
        end
    end

    always_ff @(posedge clk) begin
        grad_addr <= fifo_addr[rd_ptr];
        grad_do   <= fifo_word[rd_ptr];
    end

endmodule

`default_nettype wire

/* hw/ig_pixel_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_pixel_fetch (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire ig_pixel_pkg::coord_t  cfg_width,
    input  wire ig_pixel_pkg::coord_t  cfg_height,
    input  wire logic                  cfg_start,
    input  wire logic                  slot_free,
    output logic                       img_rd,
    output ig_pixel_pkg::mem_addr_t    img_addr,
    output logic                       pix_valid,
    output ig_pixel_pkg::coord_t       pix_col,
    output logic                       pix_first_row,
    output logic                       flush_valid
);
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`IG_FIFO_DEPTH + 1);

    fetch_state_e      state;
    coord_t            row;
    coord_t            col;
    mem_addr_t         rd_addr;
    logic [CRED_W-1:0] credits;

    logic issue_rd;
    logic issue_flush;
    logic spend;
    logic last_col;
    logic last_row;

    // ------------------------------
    // beat qualification
    // row 0 only fills the line buffer, so it needs no credit
    assign issue_rd    = (state == FETCH_READ) && ((row == '0) || (credits != '0));
    assign issue_flush = (state == FETCH_FLUSH) && (credits != '0);
    assign spend       = (issue_rd && (row != '0)) || issue_flush;

    assign last_col = (col == cfg_width - 9'd1);
    assign last_row = (row == cfg_height - 9'd1);

    assign img_rd   = issue_rd;
    assign img_addr = rd_addr;

    // internal credits mirror free fifo slots
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CRED_W'(`IG_FIFO_DEPTH);
        end else begin
            credits <= credits - CRED_W'(spend) + CRED_W'(slot_free);
        end
    end

    // ------------------------------
    // raster sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH_IDLE;
            row     <= '0;
            col     <= '0;
            rd_addr <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (cfg_start) begin
                        state   <= FETCH_READ;
                        row     <= '0;
                        col     <= '0;
                        rd_addr <= '0;
                    end
                end
                FETCH_READ: begin
                    if (issue_rd) begin
                        rd_addr <= rd_addr + 16'd1;
                        if (last_col) begin
                            col <= '0;
                            if (last_row) begin
                                state <= FETCH_FLUSH;
                            end else begin
                                row <= row + 9'd1;
                            end
                        end else begin
                            col <= col + 9'd1;
                        end
                    end
                end
                FETCH_FLUSH: begin
                    // replay of the last row out of the line buffer
                    if (issue_flush) begin
                        if (last_col) begin
                            col   <= '0;
                            state <= FETCH_DRAIN;
                        end else begin
                            col <= col + 9'd1;
                        end
                    end
                end
                FETCH_DRAIN: begin
                    if (credits == CRED_W'(`IG_FIFO_DEPTH)) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // ------------------------------
    // beat info to calc, lined up with img_di
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid   <= 1'b0;
            flush_valid <= 1'b0;
        end else begin
            pix_valid   <= issue_rd;
            flush_valid <= issue_flush;
        end
    end

    always_ff @(posedge clk) begin
        pix_col       <= col;
        pix_first_row <= (row == '0);
    end

endmodule

`default_nettype wire

/* hw/ig_pixel_pkg.sv */
`default_nettype none

package ig_pixel_pkg;

    // ------------------------------
    // image side
    // 8-bit unsigned greyscale value
    typedef logic [7:0] pixel_t;

    // ------------------------------
    // gradient side
    // signed neighbour difference, -255 to 255
    typedef logic signed [9:0] grad_comp_t;

    // gx in [19:10], gy in [9:0]
    typedef logic [19:0] grad_word_t;

    // ------------------------------
    // addressing
    // row * width + column, shared by both memories
    typedef logic [15:0] mem_addr_t;

    // row or column count, one bit wider than a pixel index so 256 fits
    typedef logic [8:0] coord_t;

endpackage

`default_nettype wire

/* hw/ig_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ig_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   cfg_wr,
    input  wire logic [1:0]             cfg_addr,
    input  wire ig_ctrl_pkg::cfg_data_t cfg_wdata,
    output ig_ctrl_pkg::cfg_data_t      cfg_rdata,
    output logic                        done,
    output logic                        img_rd,
    output ig_pixel_pkg::mem_addr_t     img_addr,
    input  wire ig_pixel_pkg::pixel_t   img_di,
    output logic                        grad_wr,
    output ig_pixel_pkg::mem_addr_t     grad_addr,
    output ig_pixel_pkg::grad_word_t    grad_do,
    input  wire logic                   grad_credit
);
    import ig_pixel_pkg::*;

    // ------------------------------
    // internal nets
    coord_t     cfg_width;
    coord_t     cfg_height;
    logic       cfg_start;
    logic       last_written;
    logic       slot_free;
    logic       pix_valid;
    coord_t     pix_col;
    logic       pix_first_row;
    logic       flush_valid;
    logic       out_valid;
    mem_addr_t  out_addr;
    grad_word_t out_word;

    ig_cfg_regs regs_i (
        .clk, .reset,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .last_written,
        .cfg_width, .cfg_height, .cfg_start, .done
    );

    ig_pixel_fetch fetch_i (
        .clk, .reset,
        .cfg_width, .cfg_height, .cfg_start,
        .slot_free,
        .img_rd, .img_addr,
        .pix_valid, .pix_col, .pix_first_row, .flush_valid
    );

    ig_grad_calc calc_i (
        .clk, .reset,
        .cfg_width, .cfg_height,
        .pix_valid, .pix_col, .pix_first_row, .flush_valid,
        .img_di,
        .out_valid, .out_addr, .out_word
    );

    ig_grad_writer writer_i (
        .clk, .reset,
        .cfg_width, .cfg_height,
        .out_valid, .out_addr, .out_word,
        .grad_credit,
        .grad_wr, .grad_addr, .grad_do,
        .slot_free, .last_written
    );

endmodule

`default_nettype wire

/* verif/ig_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_checker (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     img_rd,
    input  wire ig_pixel_pkg::mem_addr_t  img_addr,
    input  wire ig_pixel_pkg::pixel_t     img_di,
    input  wire logic                     grad_wr,
    input  wire ig_pixel_pkg::mem_addr_t  grad_addr,
    input  wire ig_pixel_pkg::grad_word_t grad_do,
    input  wire logic                     grad_credit,
    output int                            error_count,
    output int                            test_count,
    output int                            failed_count
);
    import ig_pixel_pkg::*;

    // image as seen on the read port, and which addresses got a word
    pixel_t     image [0:65535];
    logic       written [0:65535];
    int         frame_w = 1;
    int         frame_h = 1;
    int         frame_words = 0;
    logic       frame_active = 1'b0;
    int         reads = 0;
    int         words = 0;
    int         outstanding = 0;
    int         test_mark = 0;
    logic       rd_pend = 1'b0;
    mem_addr_t  rd_pend_addr;
    grad_word_t expected;

    initial begin
        error_count  = 0;
        test_count   = 0;
        failed_count = 0;
    end

    // gx from the right neighbour, gy from the pixel below, zero at the edges
    function automatic grad_word_t predict_word(input int addr);
        int p;
        int diff_x;
        int diff_y;
        p      = image[addr];
        diff_x = 0;
        diff_y = 0;
        if (addr % frame_w != frame_w - 1) begin
            diff_x = image[addr + 1];
            diff_x = diff_x - p;
        end
        if (addr / frame_w != frame_h - 1) begin
            diff_y = image[addr + frame_w];
            diff_y = diff_y - p;
        end
        return {diff_x[9:0], diff_y[9:0]};
    endfunction

    task automatic check_value(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val) begin
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp_val, act_val);
            error_count = error_count + 1;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    task automatic report_test(input string label);
        int errs;
        errs       = error_count - test_mark;
        test_mark  = error_count;
        test_count = test_count + 1;
        if (errs != 0) begin
            failed_count = failed_count + 1;
        end
        $display("test %0d (%s) finished with %0d errors", test_count, label, errs);
    endtask

    task automatic start_frame(input int w, input int h, input int n_words);
        int a;
        for (a = 0; a < w * h; a = a + 1) begin
            written[a] = 1'b0;
        end
        frame_w      = w;
        frame_h      = h;
        frame_words  = n_words;
        reads        = 0;
        words        = 0;
        frame_active = 1'b1;
    endtask

    task automatic end_frame(input string label);
        int a;
        int missing;
        missing      = 0;
        frame_active = 1'b0;
        check_value("img_rd count", frame_w * frame_h, reads);
        check_value("grad_wr count", frame_words, words);
        for (a = 0; a < frame_w * frame_h; a = a + 1) begin
            if (written[a] !== 1'b1) begin
                missing = missing + 1;
            end
        end
        if (missing != 0) begin
            report_problem($sformatf("%0d addresses never written", missing));
        end
        report_test(label);
    endtask

    // ------------------------------
    // port monitor
    always @(posedge clk) begin
        if (!reset) begin
            // pixel shows up one clock after its read
            if (rd_pend) begin
                image[rd_pend_addr] = img_di;
            end
            rd_pend = 1'b0;
            if (img_rd === 1'b1) begin
                if (!frame_active || reads >= frame_w * frame_h) begin
                    report_problem("image read outside a frame");
                end else begin
                    check_value("img_addr", reads, img_addr);
                    rd_pend      = 1'b1;
                    rd_pend_addr = img_addr;
                    reads        = reads + 1;
                end
            end
            if (grad_wr === 1'b1) begin
                if (!frame_active || grad_addr >= frame_w * frame_h) begin
                    report_problem($sformatf("write to address %0d outside a frame", grad_addr));
                end else begin
                    if (written[grad_addr] === 1'b1) begin
                        report_problem($sformatf("address %0d written twice", grad_addr));
                    end
                    written[grad_addr] = 1'b1;
                    words    = words + 1;
                    expected = predict_word(grad_addr);
                    if (grad_do !== expected) begin
                        $display("Fail at %0t: grad_do expected %h got %h (address %0d)",
                                 $time, expected, grad_do, grad_addr);
                        error_count = error_count + 1;
                    end
                end
                outstanding = outstanding + 1;
            end
            if (grad_credit === 1'b1) begin
                outstanding = outstanding - 1;
            end
            if (outstanding > `IG_GRAD_CREDITS) begin
                $display("Fail at %0t: outstanding grad_wr expected <= %0d got %0d",
                         $time, `IG_GRAD_CREDITS, outstanding);
                error_count = error_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/ig_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ig_defs.svh"

module ig_tb;
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;

    localparam int NUM_TESTS   = 11;
    localparam int PAT_RANDOM  = 0;
    localparam int PAT_HRAMP   = 1;
    localparam int PAT_VRAMP   = 2;
    localparam int PAT_CHECKER = 3;

    logic       clk;
    logic       reset;
    logic       cfg_wr;
    logic [1:0] cfg_addr;
    cfg_data_t  cfg_wdata;
    cfg_data_t  cfg_rdata;
    logic       done;
    logic       img_rd;
    mem_addr_t  img_addr;
    pixel_t     img_di = '0;
    logic       grad_wr;
    mem_addr_t  grad_addr;
    grad_word_t grad_do;
    logic       grad_credit = 1'b0;

    // image memory model
    pixel_t    img_mem [0:65535];
    logic      mem_pend = 1'b0;
    mem_addr_t mem_pend_addr;

    // credit sink state
    int owed = 0;
    int wait_cnt = 0;
    int credit_delay_max = 0;

    // test table columns
    int tbl_width  [0:NUM_TESTS-1];
    int tbl_height [0:NUM_TESTS-1];
    int tbl_delay  [0:NUM_TESTS-1];
    int tbl_kind   [0:NUM_TESTS-1];
    int tbl_words  [0:NUM_TESTS-1];

    int error_count;
    int test_count;
    int failed_count;
    int rnd;
    int rd_val;
    int i;
    bit run_ok;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ig_top dut_i (
        .clk, .reset,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .done,
        .img_rd, .img_addr, .img_di,
        .grad_wr, .grad_addr, .grad_do, .grad_credit
    );

    ig_checker checker_i (
        .clk, .reset,
        .img_rd, .img_addr, .img_di,
        .grad_wr, .grad_addr, .grad_do, .grad_credit,
        .error_count, .test_count, .failed_count
    );

    // ------------------------------
    // memory answers one clock after the read
    always @(negedge clk) begin
        if (mem_pend) begin
            img_di = img_mem[mem_pend_addr];
        end
        mem_pend      = (img_rd === 1'b1);
        mem_pend_addr = img_addr;
    end

    // one credit back per retired word, after a random wait
    always @(negedge clk) begin
        if (grad_wr === 1'b1) begin
            owed = owed + 1;
        end
        grad_credit = 1'b0;
        if (owed > 0) begin
            if (wait_cnt == 0) begin
                grad_credit = 1'b1;
                owed        = owed - 1;
                wait_cnt    = $urandom % (credit_delay_max + 1);
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    // ------------------------------
    task automatic set_row(input int idx, input int w, input int h, input int delay,
                           input int kind, input int n_words);
        tbl_width[idx]  = w;
        tbl_height[idx] = h;
        tbl_delay[idx]  = delay;
        tbl_kind[idx]   = kind;
        tbl_words[idx]  = n_words;
    endtask

    task automatic write_reg(input logic [1:0] addr, input int data);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data[15:0];
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output int value);
        @(negedge clk);
        cfg_addr = addr;
        @(negedge clk);
        value = cfg_rdata;
    endtask

    task automatic fill_image(input int w, input int h, input int kind);
        int a;
        int v;
        for (a = 0; a < w * h; a = a + 1) begin
            case (kind)
                PAT_HRAMP:   v = (a % w) * 5 + a / w;
                PAT_VRAMP:   v = 255 - (a / w) * 9 + a % w;
                PAT_CHECKER: v = ((a / w + a % w) % 2 == 1) ? 255 : 0;
                default:     v = $urandom;
            endcase
            img_mem[a] = v[7:0];
        end
    endtask

    task automatic wait_for_done(input int limit, output bit ok);
        int n;
        ok = 1'b1;
        n  = 0;
        // done of the previous frame drops shortly after start
        while (done === 1'b1 && n < 8) begin
            @(negedge clk);
            n = n + 1;
        end
        if (done === 1'b1) begin
            $display("done did not clear after start");
            ok = 1'b0;
        end
        n = 0;
        while (ok && done !== 1'b1 && n < limit) begin
            @(negedge clk);
            n = n + 1;
        end
        if (ok && done !== 1'b1) begin
            $display("timed out after %0d cycles waiting for done", limit);
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int idx, output bit ok);
        int w;
        int h;
        int limit;
        w     = tbl_width[idx];
        h     = tbl_height[idx];
        limit = (tbl_words[idx] + 2 * w) * (tbl_delay[idx] + 3) + 500;
        @(posedge clk);
        credit_delay_max = tbl_delay[idx];
        fill_image(w, h, tbl_kind[idx]);
        write_reg(`IG_REG_WIDTH, w);
        write_reg(`IG_REG_HEIGHT, h);
        checker_i.start_frame(w, h, tbl_words[idx]);
        write_reg(`IG_REG_CTRL, 1);
        wait_for_done(limit, ok);
        if (ok) begin
            checker_i.end_frame($sformatf("%0dx%0d, delay %0d", w, h, tbl_delay[idx]));
        end
    endtask

    // ------------------------------
    initial begin
        rnd       = $urandom(58);
        reset     = 1'b1;
        cfg_wr    = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = '0;
        run_ok    = 1'b1;
        set_row(0, 1, 1, 0, PAT_RANDOM, 1);
        set_row(1, 5, 3, 0, PAT_HRAMP, 15);
        set_row(2, 5, 3, 6, PAT_RANDOM, 15);
        set_row(3, 256, 2, 1, PAT_HRAMP, 512);
        set_row(4, 16, 16, 0, PAT_RANDOM, 256);
        set_row(5, 7, 9, 15, PAT_VRAMP, 63);
        set_row(6, 1, 5, 4, PAT_CHECKER, 5);
        set_row(7, 33, 4, 25, PAT_CHECKER, 132);
        set_row(8, 2, 256, 2, PAT_RANDOM, 512);
        set_row(9, 3, 1, 3, PAT_VRAMP, 3);
        set_row(10, 256, 256, 0, PAT_RANDOM, 65536);
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // register defaults straight after reset
        read_reg(`IG_REG_WIDTH, rd_val);
        checker_i.check_value("cfg_rdata width", 256, rd_val);
        read_reg(`IG_REG_HEIGHT, rd_val);
        checker_i.check_value("cfg_rdata height", 256, rd_val);
        read_reg(`IG_REG_STATUS, rd_val);
        checker_i.check_value("cfg_rdata status", 0, rd_val);
        repeat (4) @(negedge clk);
        checker_i.report_test("reset defaults");

        for (i = 0; i < NUM_TESTS && run_ok; i = i + 1) begin
            run_test(i, run_ok);
        end
        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_count, error_count);
        if (run_ok && error_count == 0 && failed_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/ig_pixel_pkg.sv
hw/ig_ctrl_pkg.sv
hw/ig_cfg_regs.sv
hw/ig_pixel_fetch.sv
hw/ig_grad_calc.sv
hw/ig_grad_writer.sv
hw/ig_top.sv
verif/ig_checker.sv
verif/ig_tb.sv
